// File: Makefile
# Verilator simulation of the tile testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f project.f --top-module tb_tile
	./obj_dir/Vtb_tile > sim.log 2>&1 || echo "Finished with errors" >> sim.log
	cat sim.log
	! grep -q "Finished with errors" sim.log

clean:
	rm -rf obj_dir sim.log

// File: hdl/core_tcdm_shim.sv
// ---------------------------------------------------------------------
// Core TCDM shim
// Steers each core request to the local or remote port by tile field,
// allows one read in flight and merges the responses
// ---------------------------------------------------------------------

module core_tcdm_shim (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  tile_pkg::tile_id_t tile_id_i,
  input  logic               core_req_i,
  input  logic               core_wen_i,
  input  tile_pkg::addr_t    core_addr_i,
  input  tile_pkg::data_t    core_wdata_i,
  input  tile_pkg::be_t      core_be_i,
  output logic               core_gnt_o,
  output logic               core_vld_o,
  output tile_pkg::data_t    core_rdata_o,
  tcdm_if.master             local_o,
  tcdm_if.master             remote_o
);
  import tile_pkg::*;

  logic is_local;
  logic taken;
  logic resp_vld;
  logic pend_q;
  logic pend_remote_q;

  assign is_local = core_addr_i[TileLsb +: $bits(tile_id_t)] == tile_id_i;

  // No new request while a read is in flight
  assign local_o.req  = core_req_i && !pend_q && is_local;
  assign remote_o.req = core_req_i && !pend_q && !is_local;

  // Crossbar picks bank and row out of the full address
  assign local_o.addr   = core_addr_i;
  assign local_o.wen    = core_wen_i;
  assign local_o.wdata  = core_wdata_i;
  assign local_o.be     = core_be_i;
  assign remote_o.addr  = core_addr_i;
  assign remote_o.wen   = core_wen_i;
  assign remote_o.wdata = core_wdata_i;
  assign remote_o.be    = core_be_i;

  assign taken      = (local_o.req && local_o.gnt) || (remote_o.req && remote_o.gnt);
  assign core_gnt_o = taken;

  assign resp_vld     = local_o.vld || remote_o.vld;
  assign core_vld_o   = resp_vld;
  assign core_rdata_o = pend_remote_q ? remote_o.rdata : local_o.rdata;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q        <= 1'b0;
      pend_remote_q <= 1'b0;
    end else if (taken && !core_wen_i) begin
      pend_q        <= 1'b1;
      pend_remote_q <= !is_local;
    end else if (resp_vld) begin
      pend_q <= 1'b0;
    end
  end

  // Responses only come from the port holding the read
  a_local_vld: assert property (@(posedge clk_i) disable iff (!rst_ni)
    local_o.vld |-> pend_q && !pend_remote_q);

  a_remote_vld: assert property (@(posedge clk_i) disable iff (!rst_ni)
    remote_o.vld |-> pend_q && pend_remote_q);

endmodule

// File: hdl/local_xbar.sv
// ---------------------------------------------------------------------
// Local crossbar
// Round-robin arbitration of core and inbound ports over the banks,
// with read responses routed back one cycle after grant
// ---------------------------------------------------------------------

`include "tile_defs.svh"

module local_xbar (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  tcdm_if.slave                                  core_i [`NUM_CORES],
  input  logic                 [`NUM_CORES-1:0]  mem_req_i,
  input  logic                 [`NUM_CORES-1:0]  mem_wen_i,
  input  tile_pkg::tile_addr_t [`NUM_CORES-1:0]  mem_addr_i,
  input  tile_pkg::data_t      [`NUM_CORES-1:0]  mem_wdata_i,
  input  tile_pkg::be_t        [`NUM_CORES-1:0]  mem_be_i,
  input  tile_pkg::core_addr_t [`NUM_CORES-1:0]  mem_ret_addr_i,
  output logic                 [`NUM_CORES-1:0]  mem_gnt_o,
  output logic                 [`NUM_CORES-1:0]  mem_vld_o,
  output tile_pkg::data_t      [`NUM_CORES-1:0]  mem_rdata_o,
  output tile_pkg::core_addr_t [`NUM_CORES-1:0]  mem_resp_addr_o,
  output logic                 [`NUM_BANKS-1:0]  bank_req_o,
  output logic                 [`NUM_BANKS-1:0]  bank_wen_o,
  output tile_pkg::row_t       [`NUM_BANKS-1:0]  bank_addr_o,
  output tile_pkg::data_t      [`NUM_BANKS-1:0]  bank_wdata_o,
  output tile_pkg::be_t        [`NUM_BANKS-1:0]  bank_be_o,
  input  tile_pkg::data_t      [`NUM_BANKS-1:0]  bank_rdata_i
);
  import tile_pkg::*;

  localparam int unsigned NumPorts = 2 * `NUM_CORES;
  typedef logic [$clog2(NumPorts)-1:0] port_t;

  // All ports side by side, cores first
  logic       [NumPorts-1:0]   in_req;
  logic       [NumPorts-1:0]   in_wen;
  bank_sel_t  [NumPorts-1:0]   in_bank;
  row_t       [NumPorts-1:0]   in_row;
  data_t      [NumPorts-1:0]   in_wdata;
  be_t        [NumPorts-1:0]   in_be;
  core_addr_t [NumPorts-1:0]   in_ret;
  logic       [NumPorts-1:0]   in_gnt;
  logic       [NumPorts-1:0]   out_vld;
  data_t      [NumPorts-1:0]   out_rdata;
  core_addr_t [NumPorts-1:0]   out_ret;

  logic       [`NUM_BANKS-1:0] found;
  port_t      [`NUM_BANKS-1:0] win;
  port_t      [`NUM_BANKS-1:0] rr_q;
  logic       [`NUM_BANKS-1:0] rd_q;
  port_t      [`NUM_BANKS-1:0] win_q;
  core_addr_t [`NUM_BANKS-1:0] ret_q;

  for (genvar c = 0; c < `NUM_CORES; c++) begin : gen_ports
    assign in_req[c]       = core_i[c].req;
    assign in_wen[c]       = core_i[c].wen;
    assign in_bank[c]      = core_i[c].addr[BankLsb +: $bits(bank_sel_t)];
    assign in_row[c]       = core_i[c].addr[RowLsb +: $bits(row_t)];
    assign in_wdata[c]     = core_i[c].wdata;
    assign in_be[c]        = core_i[c].be;
    assign in_ret[c]       = '0;
    assign core_i[c].gnt   = in_gnt[c];
    assign core_i[c].vld   = out_vld[c];
    assign core_i[c].rdata = out_rdata[c];

    // Inbound word address is {row, bank}
    assign in_req[`NUM_CORES+c]   = mem_req_i[c];
    assign in_wen[`NUM_CORES+c]   = mem_wen_i[c];
    assign in_bank[`NUM_CORES+c]  = mem_addr_i[c][$bits(bank_sel_t)-1:0];
    assign in_row[`NUM_CORES+c]   = mem_addr_i[c][$bits(tile_addr_t)-1 -: $bits(row_t)];
    assign in_wdata[`NUM_CORES+c] = mem_wdata_i[c];
    assign in_be[`NUM_CORES+c]    = mem_be_i[c];
    assign in_ret[`NUM_CORES+c]   = mem_ret_addr_i[c];
    assign mem_gnt_o[c]           = in_gnt[`NUM_CORES+c];
    assign mem_vld_o[c]           = out_vld[`NUM_CORES+c];
    assign mem_rdata_o[c]         = out_rdata[`NUM_CORES+c];
    assign mem_resp_addr_o[c]     = out_ret[`NUM_CORES+c];
  end

  // Search from each bank's pointer for the first requesting port
  always_comb begin
    port_t idx;
    found  = '0;
    win    = rr_q;
    in_gnt = '0;
    for (int b = 0; b < `NUM_BANKS; b++) begin
      for (int k = 0; k < NumPorts; k++) begin
        idx = port_t'(rr_q[b] + k);
        if (!found[b] && in_req[idx] && in_bank[idx] == bank_sel_t'(b)) begin
          found[b] = 1'b1;
          win[b]   = idx;
        end
      end
      if (found[b]) begin
        in_gnt[win[b]] = 1'b1;
      end
    end
  end

  for (genvar b = 0; b < `NUM_BANKS; b++) begin : gen_bank_out
    logic [NumPorts-1:0] hit;

    always_comb begin
      for (int p = 0; p < NumPorts; p++) begin
        hit[p] = in_req[p] && (in_bank[p] == bank_sel_t'(b));
      end
    end

    assign bank_req_o[b]   = found[b];
    assign bank_wen_o[b]   = in_wen[win[b]];
    assign bank_addr_o[b]  = in_row[win[b]];
    assign bank_wdata_o[b] = in_wdata[win[b]];
    assign bank_be_o[b]    = in_be[win[b]];

    a_one_gnt_per_bank: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $onehot0(in_gnt & hit));
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= '0;
      rd_q <= '0;
    end else begin
      for (int b = 0; b < `NUM_BANKS; b++) begin
        rd_q[b] <= found[b] && !in_wen[win[b]];
        // Winner drops to lowest priority
        if (found[b]) begin
          rr_q[b] <= port_t'(win[b] + 1'b1);
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int b = 0; b < `NUM_BANKS; b++) begin
      win_q[b] <= win[b];
      ret_q[b] <= in_ret[win[b]];
    end
  end

  // Bank data back to last cycle's read winner
  always_comb begin
    out_vld   = '0;
    out_rdata = '0;
    out_ret   = '0;
    for (int b = 0; b < `NUM_BANKS; b++) begin
      if (rd_q[b]) begin
        out_vld[win_q[b]]   = 1'b1;
        out_rdata[win_q[b]] = bank_rdata_i[b];
        out_ret[win_q[b]]   = ret_q[b];
      end
    end
  end

endmodule

// File: hdl/remote_req_register.sv
// ---------------------------------------------------------------------
// Remote request register
// Two-entry FIFO on the outbound port that reorders the address fields
// for routing in the global interconnect
// ---------------------------------------------------------------------

module remote_req_register #(
  parameter tile_pkg::core_id_t CoreIdx = '0
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  tcdm_if.slave           slv_i,
  output logic            tcdm_master_req_o,
  output logic            tcdm_master_wen_o,
  output tile_pkg::addr_t tcdm_master_addr_o,
  output tile_pkg::data_t tcdm_master_wdata_o,
  output tile_pkg::be_t   tcdm_master_be_o,
  input  logic            tcdm_master_gnt_i,
  input  logic            tcdm_master_vld_i,
  input  tile_pkg::data_t tcdm_master_rdata_i
);
  import tile_pkg::*;

  typedef struct packed {
    addr_t addr;
    logic  wen;
    data_t wdata;
    be_t   be;
  } req_t;

  req_t       in_req;
  req_t [1:0] entry_q;
  logic [1:0] count_q;
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic       push;
  logic       pop;

  // Upper zeros, row, bank, tile, core, byte offset
  assign in_req.addr  = addr_t'({slv_i.addr[RowLsb +: $bits(row_t)],
                                 slv_i.addr[BankLsb +: $bits(bank_sel_t)],
                                 slv_i.addr[TileLsb +: $bits(tile_id_t)],
                                 CoreIdx,
                                 slv_i.addr[ByteOffset-1:0]});
  assign in_req.wen   = slv_i.wen;
  assign in_req.wdata = slv_i.wdata;
  assign in_req.be    = slv_i.be;

  assign slv_i.gnt = count_q != 2'd2;
  assign push      = slv_i.req && slv_i.gnt;
  assign pop       = tcdm_master_req_o && tcdm_master_gnt_i;

  assign tcdm_master_req_o   = count_q != 2'd0;
  assign tcdm_master_addr_o  = entry_q[rd_ptr_q].addr;
  assign tcdm_master_wen_o   = entry_q[rd_ptr_q].wen;
  assign tcdm_master_wdata_o = entry_q[rd_ptr_q].wdata;
  assign tcdm_master_be_o    = entry_q[rd_ptr_q].be;

  // Responses go straight back to the shim
  assign slv_i.vld   = tcdm_master_vld_i;
  assign slv_i.rdata = tcdm_master_rdata_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q  <= '0;
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= !wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= !rd_ptr_q;
      end
      if (push && !pop) begin
        count_q <= count_q + 2'd1;
      end else if (pop && !push) begin
        count_q <= count_q - 2'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      entry_q[wr_ptr_q] <= in_req;
    end
  end

  a_hold_until_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tcdm_master_req_o && !tcdm_master_gnt_i |=> tcdm_master_req_o &&
      $stable({tcdm_master_addr_o, tcdm_master_wen_o, tcdm_master_wdata_o, tcdm_master_be_o}));

endmodule

// File: hdl/tcdm_bank.sv
// ---------------------------------------------------------------------
// TCDM bank
// Single-port memory with byte-masked writes and registered reads
// ---------------------------------------------------------------------

`include "tile_defs.svh"

module tcdm_bank (
  input  logic            clk_i,
  input  logic            req_i,
  input  logic            we_i,
  input  tile_pkg::row_t  addr_i,
  input  tile_pkg::data_t wdata_i,
  input  tile_pkg::be_t   be_i,
  output tile_pkg::data_t rdata_o
);
  import tile_pkg::*;

  data_t mem_q [`BANK_WORDS];
  data_t bit_mask;

  // Each byte enable covers eight data bits
  for (genvar i = 0; i < $bits(be_t); i++) begin : gen_mask
    assign bit_mask[8*i +: 8] = {8{be_i[i]}};
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        mem_q[addr_i] <= (mem_q[addr_i] & ~bit_mask) | (wdata_i & bit_mask);
      end else begin
        // Read data valid the cycle after the request
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

// File: hdl/tcdm_if.sv
// ---------------------------------------------------------------------
// TCDM port
// One req/gnt request channel with a vld read response
// ---------------------------------------------------------------------

interface tcdm_if;
  import tile_pkg::*;

  // Request, held until gnt
  logic  req;
  addr_t addr;
  logic  wen;
  data_t wdata;
  be_t   be;
  logic  gnt;

  // One vld per taken read
  logic  vld;
  data_t rdata;

  modport master (
    output req, addr, wen, wdata, be,
    input  gnt, vld, rdata
  );

  modport slave (
    input  req, addr, wen, wdata, be,
    output gnt, vld, rdata
  );

endinterface

// File: hdl/tile.sv
// ---------------------------------------------------------------------
// Tile data path
// Core shims, remote request registers, local crossbar and TCDM banks
// ---------------------------------------------------------------------

`include "tile_defs.svh"

module tile (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  tile_pkg::tile_id_t                    tile_id_i,
  // Core data ports
  input  logic                 [`NUM_CORES-1:0] core_req_i,
  input  logic                 [`NUM_CORES-1:0] core_wen_i,
  input  tile_pkg::addr_t      [`NUM_CORES-1:0] core_addr_i,
  input  tile_pkg::data_t      [`NUM_CORES-1:0] core_wdata_i,
  input  tile_pkg::be_t        [`NUM_CORES-1:0] core_be_i,
  output logic                 [`NUM_CORES-1:0] core_gnt_o,
  output logic                 [`NUM_CORES-1:0] core_vld_o,
  output tile_pkg::data_t      [`NUM_CORES-1:0] core_rdata_o,
  // Outbound remote ports
  output logic                 [`NUM_CORES-1:0] tcdm_master_req_o,
  output logic                 [`NUM_CORES-1:0] tcdm_master_wen_o,
  output tile_pkg::addr_t      [`NUM_CORES-1:0] tcdm_master_addr_o,
  output tile_pkg::data_t      [`NUM_CORES-1:0] tcdm_master_wdata_o,
  output tile_pkg::be_t        [`NUM_CORES-1:0] tcdm_master_be_o,
  input  logic                 [`NUM_CORES-1:0] tcdm_master_gnt_i,
  input  logic                 [`NUM_CORES-1:0] tcdm_master_vld_i,
  input  tile_pkg::data_t      [`NUM_CORES-1:0] tcdm_master_rdata_i,
  // Inbound remote ports
  input  logic                 [`NUM_CORES-1:0] mem_req_i,
  input  logic                 [`NUM_CORES-1:0] mem_wen_i,
  input  tile_pkg::tile_addr_t [`NUM_CORES-1:0] mem_addr_i,
  input  tile_pkg::data_t      [`NUM_CORES-1:0] mem_wdata_i,
  input  tile_pkg::be_t        [`NUM_CORES-1:0] mem_be_i,
  input  tile_pkg::core_addr_t [`NUM_CORES-1:0] mem_ret_addr_i,
  output logic                 [`NUM_CORES-1:0] mem_gnt_o,
  output logic                 [`NUM_CORES-1:0] mem_vld_o,
  output tile_pkg::data_t      [`NUM_CORES-1:0] mem_rdata_o,
  output tile_pkg::core_addr_t [`NUM_CORES-1:0] mem_resp_addr_o
);
  import tile_pkg::*;

  tcdm_if local_if  [`NUM_CORES] ();
  tcdm_if remote_if [`NUM_CORES] ();

  logic  [`NUM_BANKS-1:0] bank_req;
  logic  [`NUM_BANKS-1:0] bank_wen;
  row_t  [`NUM_BANKS-1:0] bank_addr;
  data_t [`NUM_BANKS-1:0] bank_wdata;
  be_t   [`NUM_BANKS-1:0] bank_be;
  data_t [`NUM_BANKS-1:0] bank_rdata;

  for (genvar c = 0; c < `NUM_CORES; c++) begin : gen_cores
    core_tcdm_shim i_shim (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .tile_id_i    (tile_id_i),
      .core_req_i   (core_req_i[c]),
      .core_wen_i   (core_wen_i[c]),
      .core_addr_i  (core_addr_i[c]),
      .core_wdata_i (core_wdata_i[c]),
      .core_be_i    (core_be_i[c]),
      .core_gnt_o   (core_gnt_o[c]),
      .core_vld_o   (core_vld_o[c]),
      .core_rdata_o (core_rdata_o[c]),
      .local_o      (local_if[c]),
      .remote_o     (remote_if[c])
    );

    // Core index goes into the outbound address
    remote_req_register #(
      .CoreIdx (core_id_t'(c))
    ) i_remote_reg (
      .clk_i               (clk_i),
      .rst_ni              (rst_ni),
      .slv_i               (remote_if[c]),
      .tcdm_master_req_o   (tcdm_master_req_o[c]),
      .tcdm_master_wen_o   (tcdm_master_wen_o[c]),
      .tcdm_master_addr_o  (tcdm_master_addr_o[c]),
      .tcdm_master_wdata_o (tcdm_master_wdata_o[c]),
      .tcdm_master_be_o    (tcdm_master_be_o[c]),
      .tcdm_master_gnt_i   (tcdm_master_gnt_i[c]),
      .tcdm_master_vld_i   (tcdm_master_vld_i[c]),
      .tcdm_master_rdata_i (tcdm_master_rdata_i[c])
    );
  end

  local_xbar i_local_xbar (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .core_i          (local_if),
    .mem_req_i       (mem_req_i),
    .mem_wen_i       (mem_wen_i),
    .mem_addr_i      (mem_addr_i),
    .mem_wdata_i     (mem_wdata_i),
    .mem_be_i        (mem_be_i),
    .mem_ret_addr_i  (mem_ret_addr_i),
    .mem_gnt_o       (mem_gnt_o),
    .mem_vld_o       (mem_vld_o),
    .mem_rdata_o     (mem_rdata_o),
    .mem_resp_addr_o (mem_resp_addr_o),
    .bank_req_o      (bank_req),
    .bank_wen_o      (bank_wen),
    .bank_addr_o     (bank_addr),
    .bank_wdata_o    (bank_wdata),
    .bank_be_o       (bank_be),
    .bank_rdata_i    (bank_rdata)
  );

  // Banks always grant
  for (genvar b = 0; b < `NUM_BANKS; b++) begin : gen_banks
    tcdm_bank i_bank (
      .clk_i   (clk_i),
      .req_i   (bank_req[b]),
      .we_i    (bank_wen[b]),
      .addr_i  (bank_addr[b]),
      .wdata_i (bank_wdata[b]),
      .be_i    (bank_be[b]),
      .rdata_o (bank_rdata[b])
    );
  end

endmodule

// File: hdl/tile_defs.svh
// ---------------------------------------------------------------------
// Tile size macros
// Core, bank and tile counts, bank depth and data width
// ---------------------------------------------------------------------

`ifndef TILE_DEFS_SVH
`define TILE_DEFS_SVH

// Cores per tile, one inbound port each
`define NUM_CORES 4

// Banks per tile
`define NUM_BANKS 8

// Tiles in the cluster
`define NUM_TILES 4

// Words per bank
`define BANK_WORDS 256

`define DATA_WIDTH 32

`endif

// File: hdl/tile_pkg.sv
// ---------------------------------------------------------------------
// Tile types
// Address, data and index types plus the fields of a shared-L1 address
// ---------------------------------------------------------------------

`include "tile_defs.svh"

package tile_pkg;

  typedef logic [`DATA_WIDTH-1:0]         data_t;
  typedef logic [`DATA_WIDTH/8-1:0]       be_t;
  typedef logic [31:0]                    addr_t;
  typedef logic [$clog2(`NUM_TILES)-1:0]  tile_id_t;
  typedef logic [$clog2(`NUM_CORES)-1:0]  core_id_t;
  typedef logic [$clog2(`NUM_BANKS)-1:0]  bank_sel_t;
  typedef logic [$clog2(`BANK_WORDS)-1:0] row_t;

  // Word address inside a tile, row above bank
  typedef logic [$bits(row_t)+$bits(bank_sel_t)-1:0] tile_addr_t;

  // Requester tile and core plus spare bits
  typedef logic [7:0] core_addr_t;

  // Byte address layout from bit 0 upward
  localparam int unsigned ByteOffset = $clog2(`DATA_WIDTH/8);
  localparam int unsigned BankLsb    = ByteOffset;
  localparam int unsigned TileLsb    = BankLsb + $bits(bank_sel_t);
  localparam int unsigned RowLsb     = TileLsb + $bits(tile_id_t);

endpackage

// File: project.f
+incdir+hdl
hdl/tile_pkg.sv
hdl/tcdm_if.sv
hdl/tcdm_bank.sv
hdl/local_xbar.sv
hdl/core_tcdm_shim.sv
hdl/remote_req_register.sv
hdl/tile.sv
verification/tb_tile.sv

// File: verification/tb_tile.sv
// ----------------------------------------------------------------------
// Tile testbench
// Random core and inbound traffic checked against a memory model and
// a model of the remote fabric
// ----------------------------------------------------------------------

`include "tile_defs.svh"

module tb_tile;
  import tile_pkg::*;

  localparam int       Cycles      = 2000;
  localparam int       ReqTimeout  = 200;
  localparam int       RespTimeout = 100;
  localparam int       DrainCycles = 500;
  localparam int       Words       = 2 ** $bits(tile_addr_t);
  localparam tile_id_t OwnTile     = 2'd2;

  typedef struct packed {
    addr_t addr;
    logic  wen;
    data_t wdata;
    be_t   be;
  } out_req_t;

  logic                        clk_i;
  logic                        rst_ni;
  logic       [`NUM_CORES-1:0] core_req;
  logic       [`NUM_CORES-1:0] core_wen;
  addr_t      [`NUM_CORES-1:0] core_addr;
  data_t      [`NUM_CORES-1:0] core_wdata;
  be_t        [`NUM_CORES-1:0] core_be;
  logic       [`NUM_CORES-1:0] core_gnt;
  logic       [`NUM_CORES-1:0] core_vld;
  data_t      [`NUM_CORES-1:0] core_rdata;
  logic       [`NUM_CORES-1:0] out_req;
  logic       [`NUM_CORES-1:0] out_wen;
  addr_t      [`NUM_CORES-1:0] out_addr;
  data_t      [`NUM_CORES-1:0] out_wdata;
  be_t        [`NUM_CORES-1:0] out_be;
  logic       [`NUM_CORES-1:0] out_gnt;
  logic       [`NUM_CORES-1:0] out_vld;
  data_t      [`NUM_CORES-1:0] out_rdata;
  logic       [`NUM_CORES-1:0] mem_req;
  logic       [`NUM_CORES-1:0] mem_wen;
  tile_addr_t [`NUM_CORES-1:0] mem_addr;
  data_t      [`NUM_CORES-1:0] mem_wdata;
  be_t        [`NUM_CORES-1:0] mem_be;
  core_addr_t [`NUM_CORES-1:0] mem_ret;
  logic       [`NUM_CORES-1:0] mem_gnt;
  logic       [`NUM_CORES-1:0] mem_vld;
  data_t      [`NUM_CORES-1:0] mem_rdata;
  core_addr_t [`NUM_CORES-1:0] mem_resp;

  // Tile memory model, bytes written so far kept per word
  data_t    mem_model [Words];
  be_t      mem_known [Words];
  integer   seed;
  logic     drain;

  // Core request hold, read tracking and fabric state
  logic     core_taken [`NUM_CORES];
  int       core_wait  [`NUM_CORES];
  logic     rd_pend    [`NUM_CORES];
  logic     lvld_exp   [`NUM_CORES];
  data_t    rd_data    [`NUM_CORES];
  data_t    rd_mask    [`NUM_CORES];
  int       rd_wait    [`NUM_CORES];
  out_req_t out_q      [`NUM_CORES][$];
  logic     resp_busy  [`NUM_CORES];
  int       resp_delay [`NUM_CORES];
  data_t    resp_data  [`NUM_CORES];

  // Inbound ports
  logic       mem_taken [`NUM_CORES];
  int         mem_wait  [`NUM_CORES];
  logic       mvld_exp  [`NUM_CORES];
  data_t      mvld_data [`NUM_CORES];
  data_t      mvld_mask [`NUM_CORES];
  core_addr_t mvld_ret  [`NUM_CORES];

  tile dut_i (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .tile_id_i           (OwnTile),
    .core_req_i          (core_req),
    .core_wen_i          (core_wen),
    .core_addr_i         (core_addr),
    .core_wdata_i        (core_wdata),
    .core_be_i           (core_be),
    .core_gnt_o          (core_gnt),
    .core_vld_o          (core_vld),
    .core_rdata_o        (core_rdata),
    .tcdm_master_req_o   (out_req),
    .tcdm_master_wen_o   (out_wen),
    .tcdm_master_addr_o  (out_addr),
    .tcdm_master_wdata_o (out_wdata),
    .tcdm_master_be_o    (out_be),
    .tcdm_master_gnt_i   (out_gnt),
    .tcdm_master_vld_i   (out_vld),
    .tcdm_master_rdata_i (out_rdata),
    .mem_req_i           (mem_req),
    .mem_wen_i           (mem_wen),
    .mem_addr_i          (mem_addr),
    .mem_wdata_i         (mem_wdata),
    .mem_be_i            (mem_be),
    .mem_ret_addr_i      (mem_ret),
    .mem_gnt_o           (mem_gnt),
    .mem_vld_o           (mem_vld),
    .mem_rdata_o         (mem_rdata),
    .mem_resp_addr_o     (mem_resp)
  );

  always #20 clk_i = ~clk_i;

  function automatic int unsigned rnd_below(int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic data_t byte_mask(be_t be);
    data_t m;
    m = '0;
    for (int i = 0; i < $bits(be_t); i++) begin
      if (be[i]) begin
        m[8*i +: 8] = 8'hff;
      end
    end
    return m;
  endfunction

  function automatic logic is_local(addr_t a);
    return a[TileLsb +: 2] == OwnTile;
  endfunction

  function automatic tile_addr_t word_of(addr_t a);
    return {a[RowLsb +: 8], a[BankLsb +: 3]};
  endfunction

  // Outbound layout from the top: zeros, row, bank, tile, core, byte offset
  function automatic addr_t remote_addr(addr_t a, int core);
    addr_t r;
    r = '0;
    r[1:0]  = a[1:0];
    r[3:2]  = core[1:0];
    r[5:4]  = a[TileLsb +: 2];
    r[8:6]  = a[BankLsb +: 3];
    r[16:9] = a[RowLsb +: 8];
    return r;
  endfunction

  // Remote memory contents as the fabric returns them
  function automatic data_t fabric_data(addr_t a);
    return {~a[15:0], a[15:0]} ^ 32'h3c5a_96e1;
  endfunction

  // Mostly local, few rows so reads hit earlier writes
  function automatic addr_t rand_addr();
    addr_t a;
    a = '0;
    a[1:0]          = 2'(rnd_below(4));
    a[BankLsb +: 3] = 3'(rnd_below(8));
    a[TileLsb +: 2] = (rnd_below(5) < 3) ? OwnTile : tile_id_t'(rnd_below(4));
    a[RowLsb +: 8]  = 8'(rnd_below(16));
    return a;
  endfunction

  function automatic logic all_idle();
    logic idle;
    idle = 1'b1;
    for (int c = 0; c < `NUM_CORES; c++) begin
      if (core_req[c] || mem_req[c] || rd_pend[c] || resp_busy[c] || mvld_exp[c] ||
          out_q[c].size() != 0) begin
        idle = 1'b0;
      end
    end
    return idle;
  endfunction

  task automatic abort(string why);
    $display("%s at time %0t", why, $time);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail at time %0t: %s is %h, expected %h", $time, name, got, exp);
      abort("Value mismatch");
    end
  endtask

  task automatic model_write(tile_addr_t w, data_t wdata, be_t be);
    data_t m;
    m = byte_mask(be);
    mem_model[w] = (mem_model[w] & ~m) | (wdata & m);
    mem_known[w] = mem_known[w] | be;
  endtask

  task automatic drive_inputs();
    for (int c = 0; c < `NUM_CORES; c++) begin
      if (core_taken[c]) begin
        core_req[c]   = 1'b0;
        core_taken[c] = 1'b0;
      end
      if (!core_req[c] && !drain && rnd_below(2) == 0) begin
        core_req[c]   = 1'b1;
        core_wen[c]   = rnd_below(2) == 0;
        core_addr[c]  = rand_addr();
        core_wdata[c] = $random(seed);
        core_be[c]    = be_t'(rnd_below(16));
      end
      // Fabric grants at random and answers reads after a countdown
      out_gnt[c] = rnd_below(3) == 0;
      out_vld[c] = 1'b0;
      if (resp_busy[c]) begin
        resp_delay[c]--;
        if (resp_delay[c] == 0) begin
          out_vld[c]   = 1'b1;
          out_rdata[c] = resp_data[c];
          resp_busy[c] = 1'b0;
        end
      end
      if (mem_taken[c]) begin
        mem_req[c]   = 1'b0;
        mem_taken[c] = 1'b0;
      end
      if (!mem_req[c] && !drain && rnd_below(3) == 0) begin
        mem_req[c]   = 1'b1;
        mem_wen[c]   = rnd_below(2) == 0;
        mem_addr[c]  = {8'(rnd_below(16)), 3'(rnd_below(8))};
        mem_wdata[c] = $random(seed);
        mem_be[c]    = be_t'(rnd_below(16));
        mem_ret[c]   = core_addr_t'(rnd_below(256));
      end
    end
  endtask

  task automatic sample_outputs();
    out_req_t   head;
    out_req_t   ent;
    tile_addr_t w;
    logic       exp_vld;
    for (int c = 0; c < `NUM_CORES; c++) begin
      // Outbound port follows the order of remote issue
      if (out_req[c]) begin
        if (out_q[c].size() == 0) begin
          abort($sformatf("Core %0d sent an outbound request it never issued", c));
        end
        head = out_q[c][0];
        check($sformatf("tcdm_master_addr_o[%0d]", c), out_addr[c], head.addr);
        check($sformatf("tcdm_master_wen_o[%0d]", c), 32'(out_wen[c]), 32'(head.wen));
        check($sformatf("tcdm_master_wdata_o[%0d]", c), out_wdata[c], head.wdata);
        check($sformatf("tcdm_master_be_o[%0d]", c), 32'(out_be[c]), 32'(head.be));
        if (out_gnt[c]) begin
          void'(out_q[c].pop_front());
          if (!head.wen) begin
            resp_busy[c]  = 1'b1;
            resp_delay[c] = 1 + int'(rnd_below(5));
            resp_data[c]  = fabric_data(head.addr);
          end
        end
      end

      if (core_gnt[c] && !core_req[c]) begin
        abort($sformatf("Core %0d was granted without a request", c));
      end
      if (core_gnt[c] && rd_pend[c]) begin
        abort($sformatf("Core %0d was granted while its read was outstanding", c));
      end
      exp_vld = lvld_exp[c] || out_vld[c];
      check($sformatf("core_vld_o[%0d]", c), 32'(core_vld[c]), 32'(exp_vld));
      if (core_vld[c]) begin
        check($sformatf("core_rdata_o[%0d]", c), core_rdata[c] & rd_mask[c],
              rd_data[c] & rd_mask[c]);
        rd_pend[c] = 1'b0;
      end
      lvld_exp[c] = 1'b0;
      if (core_gnt[c]) begin
        core_taken[c] = 1'b1;
        core_wait[c]  = 0;
        if (is_local(core_addr[c])) begin
          w = word_of(core_addr[c]);
          if (core_wen[c]) begin
            model_write(w, core_wdata[c], core_be[c]);
          end else begin
            lvld_exp[c] = 1'b1;
            rd_data[c]  = mem_model[w];
            rd_mask[c]  = byte_mask(mem_known[w]);
          end
        end else begin
          ent.addr  = remote_addr(core_addr[c], c);
          ent.wen   = core_wen[c];
          ent.wdata = core_wdata[c];
          ent.be    = core_be[c];
          out_q[c].push_back(ent);
          if (!core_wen[c]) begin
            rd_data[c] = fabric_data(ent.addr);
            rd_mask[c] = '1;
          end
        end
        if (!core_wen[c]) begin
          rd_pend[c] = 1'b1;
          rd_wait[c] = 0;
        end
      end else if (core_req[c]) begin
        core_wait[c]++;
        if (core_wait[c] > ReqTimeout) begin
          abort($sformatf("Core %0d request was never granted", c));
        end
      end
      if (rd_pend[c]) begin
        rd_wait[c]++;
        if (rd_wait[c] > RespTimeout) begin
          abort($sformatf("Core %0d read never got its response", c));
        end
      end

      // Inbound responses one cycle after grant, reads only
      check($sformatf("mem_vld_o[%0d]", c), 32'(mem_vld[c]), 32'(mvld_exp[c]));
      if (mvld_exp[c]) begin
        check($sformatf("mem_rdata_o[%0d]", c), mem_rdata[c] & mvld_mask[c],
              mvld_data[c] & mvld_mask[c]);
        check($sformatf("mem_resp_addr_o[%0d]", c), 32'(mem_resp[c]), 32'(mvld_ret[c]));
      end
      mvld_exp[c] = 1'b0;
      if (mem_gnt[c]) begin
        if (!mem_req[c]) begin
          abort($sformatf("Inbound port %0d was granted without a request", c));
        end
        mem_taken[c] = 1'b1;
        mem_wait[c]  = 0;
        if (mem_wen[c]) begin
          model_write(mem_addr[c], mem_wdata[c], mem_be[c]);
        end else begin
          mvld_exp[c]  = 1'b1;
          mvld_data[c] = mem_model[mem_addr[c]];
          mvld_mask[c] = byte_mask(mem_known[mem_addr[c]]);
          mvld_ret[c]  = mem_ret[c];
        end
      end else if (mem_req[c]) begin
        mem_wait[c]++;
        if (mem_wait[c] > ReqTimeout) begin
          abort($sformatf("Inbound port %0d request was never granted", c));
        end
      end
    end
  endtask

  // Drive on the falling edge, sample a quarter period before the rising edge
  task automatic run_cycle();
    @(negedge clk_i);
    drive_inputs();
    #10;
    sample_outputs();
  endtask

  initial begin
    seed       = 32'he872;
    clk_i      = 1'b0;
    rst_ni     = 1'b0;
    drain      = 1'b0;
    core_req   = '0;
    core_wen   = '0;
    core_addr  = '0;
    core_wdata = '0;
    core_be    = '0;
    out_gnt    = '0;
    out_vld    = '0;
    out_rdata  = '0;
    mem_req    = '0;
    mem_wen    = '0;
    mem_addr   = '0;
    mem_wdata  = '0;
    mem_be     = '0;
    mem_ret    = '0;
    for (int w = 0; w < Words; w++) begin
      mem_model[w] = '0;
      mem_known[w] = '0;
    end
    for (int c = 0; c < `NUM_CORES; c++) begin
      core_taken[c] = 1'b0;
      core_wait[c]  = 0;
      rd_pend[c]    = 1'b0;
      lvld_exp[c]   = 1'b0;
      rd_wait[c]    = 0;
      resp_busy[c]  = 1'b0;
      resp_delay[c] = 0;
      mem_taken[c]  = 1'b0;
      mem_wait[c]   = 0;
      mvld_exp[c]   = 1'b0;
    end

    // Idle inputs during reset
    for (int i = 0; i < 16; i++) begin
      @(negedge clk_i);
      #10;
      check("core_gnt_o", 32'(core_gnt), '0);
      check("core_vld_o", 32'(core_vld), '0);
      check("tcdm_master_req_o", 32'(out_req), '0);
      check("mem_gnt_o", 32'(mem_gnt), '0);
      check("mem_vld_o", 32'(mem_vld), '0);
    end
    @(negedge clk_i);
    rst_ni = 1'b1;

    for (int i = 0; i < Cycles; i++) begin
      run_cycle();
    end
    drain = 1'b1;
    for (int i = 0; i < DrainCycles && !all_idle(); i++) begin
      run_cycle();
    end
    if (!all_idle()) begin
      abort("Traffic did not drain before the timeout");
    end else begin
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule
